// ==== logic/bus_pkg.sv ====
package bus_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths and counts
    //////////////////////////////////////////////////////////////////////
    localparam int word_bits      = 32;
    localparam int beats_max      = 4;
    localparam int num_sources    = 2;
    localparam int num_sinks      = 2;
    localparam int bytes_per_beat = 4;

    typedef logic [word_bits-1:0]           word_t;
    typedef logic [word_bits*beats_max-1:0] block_t;
    typedef logic [14:0]                    addr_t;
    typedef logic [3:0]                     node_t;
    typedef logic [15:0]                    size_t;
    typedef logic [2:0]                     beat_cnt_t;
    typedef logic [0:0]                     source_t;

    typedef enum logic [1:0] {
        ser_free,
        ser_request,
        ser_wait_grant,
        ser_send
    } ser_state_t;

    typedef enum logic [1:0] {
        ctl_idle,
        ctl_ack,
        ctl_grant,
        ctl_busy
    } ctl_state_t;

    // beats needed for a byte count, rounded up and kept in 1..beats_max
    function automatic beat_cnt_t beats_for_size(size_t size);
        size_t rounded;
        rounded = (size + size_t'(bytes_per_beat - 1)) / size_t'(bytes_per_beat);
        if (rounded == '0) begin
            return beat_cnt_t'(1);
        end
        if (rounded > size_t'(beats_max)) begin
            return beat_cnt_t'(beats_max);
        end
        return beat_cnt_t'(rounded);
    endfunction

endpackage

// ==== logic/bus_serializer.sv ====
`timescale 1ns/1ps

module bus_serializer (
    input  logic            clk_bus,
    input  logic            reset,

    // client side
    input  logic            blk_valid,
    input  bus_pkg::addr_t  blk_addr,
    input  bus_pkg::block_t blk_data,
    input  bus_pkg::node_t  blk_dest,
    input  bus_pkg::node_t  blk_return,
    input  logic            blk_rw,
    input  bus_pkg::size_t  blk_size,
    output logic            free_block,
    output logic            full_block,

    // handshake with the bus controller
    input  logic            ack,
    input  logic            grant,
    output logic            req,
    output logic            rel,

    // beat toward the bus mux
    output logic            beat_valid,
    output bus_pkg::addr_t  beat_addr,
    output bus_pkg::word_t  beat_data,
    output bus_pkg::node_t  beat_dest,
    output bus_pkg::node_t  beat_return,
    output logic            beat_rw,
    output bus_pkg::size_t  beat_size
);

    bus_pkg::ser_state_t state;
    bus_pkg::ser_state_t state_next;

    bus_pkg::block_t     held_data;
    bus_pkg::addr_t      held_addr;
    bus_pkg::node_t      held_dest;
    bus_pkg::node_t      held_return;
    logic                held_rw;
    bus_pkg::size_t      held_size;

    bus_pkg::beat_cnt_t  beats_left;
    logic [$clog2(bus_pkg::beats_max)-1:0] word_idx;
    logic                accept;

    assign accept = blk_valid && free_block;

    //////////////////////////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        state_next = state;
        case (state)
            bus_pkg::ser_free: begin
                if (accept) begin
                    state_next = bus_pkg::ser_request;
                end
            end
            bus_pkg::ser_request: begin
                if (ack) begin
                    state_next = bus_pkg::ser_wait_grant;
                end
            end
            bus_pkg::ser_wait_grant: begin
                if (grant) begin
                    state_next = bus_pkg::ser_send;
                end
            end
            default: begin
                // leave once the last beat is out
                if (rel) begin
                    state_next = bus_pkg::ser_free;
                end
            end
        endcase
    end

    always_ff @(posedge clk_bus) begin
        if (reset) begin
            state      <= bus_pkg::ser_free;
            beats_left <= '0;
            word_idx   <= '0;
        end else begin
            state <= state_next;
            if (accept) begin
                beats_left <= bus_pkg::beats_for_size(blk_size);
                word_idx   <= '0;
            end else if (state == bus_pkg::ser_send) begin
                beats_left <= beats_left - 1'b1;
                word_idx   <= word_idx + 1'b1;
            end
        end
    end

    // held block, only loaded on accept
    always_ff @(posedge clk_bus) begin
        if (accept) begin
            held_data   <= blk_data;
            held_addr   <= blk_addr;
            held_dest   <= blk_dest;
            held_return <= blk_return;
            held_rw     <= blk_rw;
            held_size   <= blk_size;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////////////////////////
    assign free_block = (state == bus_pkg::ser_free);
    assign full_block = !free_block;
    assign req        = (state == bus_pkg::ser_request);
    assign rel        = (state == bus_pkg::ser_send) && (beats_left == bus_pkg::beat_cnt_t'(1));

    // lowest word goes first
    assign beat_valid  = (state == bus_pkg::ser_send);
    assign beat_data   = held_data[word_idx*bus_pkg::word_bits +: bus_pkg::word_bits];
    assign beat_addr   = held_addr;
    assign beat_dest   = held_dest;
    assign beat_return = held_return;
    assign beat_rw     = held_rw;
    assign beat_size   = held_size;

endmodule

// ==== logic/bus_controller.sv ====
`timescale 1ns/1ps

module bus_controller (
    input  logic            clk_bus,
    input  logic            reset,

    input  logic            req         [bus_pkg::num_sources],
    input  logic            rel         [bus_pkg::num_sources],
    output logic            ack         [bus_pkg::num_sources],
    output logic            grant       [bus_pkg::num_sources],

    // beats from each source
    input  logic            beat_valid  [bus_pkg::num_sources],
    input  bus_pkg::addr_t  beat_addr   [bus_pkg::num_sources],
    input  bus_pkg::word_t  beat_data   [bus_pkg::num_sources],
    input  bus_pkg::node_t  beat_dest   [bus_pkg::num_sources],
    input  bus_pkg::node_t  beat_return [bus_pkg::num_sources],
    input  logic            beat_rw     [bus_pkg::num_sources],
    input  bus_pkg::size_t  beat_size   [bus_pkg::num_sources],

    // shared bus
    output logic            bus_valid,
    output bus_pkg::addr_t  bus_addr,
    output bus_pkg::word_t  bus_data,
    output bus_pkg::node_t  bus_dest,
    output bus_pkg::node_t  bus_return,
    output logic            bus_rw,
    output bus_pkg::size_t  bus_size
);

    // ack side only uses ctl_idle and ctl_ack, bus side the other three
    bus_pkg::ctl_state_t ack_state;
    bus_pkg::ctl_state_t bus_state;
    bus_pkg::source_t    ack_src;
    bus_pkg::source_t    owner;
    bus_pkg::source_t    last_winner;
    logic [bus_pkg::num_sources-1:0] pending;

    logic                ack_found;
    bus_pkg::source_t    ack_pick;
    logic                grant_found;
    bus_pkg::source_t    grant_pick;
    logic                bus_free;
    logic                do_ack;
    logic                do_grant;

    //////////////////////////////////////////////////////////////////////
    // selection
    //////////////////////////////////////////////////////////////////////
    // lowest requesting source that is not yet acknowledged
    always_comb begin
        ack_found = 1'b0;
        ack_pick  = '0;
        for (int i = bus_pkg::num_sources - 1; i >= 0; i--) begin
            if (req[i] && !pending[i]) begin
                ack_found = 1'b1;
                ack_pick  = bus_pkg::source_t'(i);
            end
        end
    end

    // round robin, the source after the last winner first
    always_comb begin
        int idx;
        grant_found = 1'b0;
        grant_pick  = last_winner;
        for (int k = bus_pkg::num_sources; k >= 1; k--) begin
            idx = (int'(last_winner) + k) % bus_pkg::num_sources;
            if (pending[idx]) begin
                grant_found = 1'b1;
                grant_pick  = bus_pkg::source_t'(idx);
            end
        end
    end

    // owner's release frees the bus for a grant in the next cycle
    assign bus_free = (bus_state == bus_pkg::ctl_idle) ||
                      ((bus_state == bus_pkg::ctl_busy) && rel[owner]);
    assign do_ack   = (ack_state == bus_pkg::ctl_idle) && ack_found;
    assign do_grant = bus_free && grant_found;

    //////////////////////////////////////////////////////////////////////
    // state
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_bus) begin
        if (reset) begin
            ack_state   <= bus_pkg::ctl_idle;
            bus_state   <= bus_pkg::ctl_idle;
            ack_src     <= '0;
            owner       <= '0;
            last_winner <= bus_pkg::source_t'(bus_pkg::num_sources - 1);
            pending     <= '0;
        end else begin
            if (do_ack) begin
                ack_state <= bus_pkg::ctl_ack;
                ack_src   <= ack_pick;
            end else begin
                ack_state <= bus_pkg::ctl_idle;
            end

            if (do_grant) begin
                bus_state   <= bus_pkg::ctl_grant;
                owner       <= grant_pick;
                last_winner <= grant_pick;
            end else if (bus_state == bus_pkg::ctl_grant) begin
                bus_state <= bus_pkg::ctl_busy;
            end else if (bus_free) begin
                bus_state <= bus_pkg::ctl_idle;
            end

            for (int i = 0; i < bus_pkg::num_sources; i++) begin
                if (do_ack && (ack_pick == bus_pkg::source_t'(i))) begin
                    pending[i] <= 1'b1;
                end else if (do_grant && (grant_pick == bus_pkg::source_t'(i))) begin
                    pending[i] <= 1'b0;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < bus_pkg::num_sources; i++) begin
            ack[i]   = (ack_state == bus_pkg::ctl_ack) && (ack_src == bus_pkg::source_t'(i));
            grant[i] = (bus_state == bus_pkg::ctl_grant) && (owner == bus_pkg::source_t'(i));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // bus mux
    //////////////////////////////////////////////////////////////////////
    assign bus_valid  = (bus_state == bus_pkg::ctl_busy) && beat_valid[owner];
    assign bus_addr   = beat_addr[owner];
    assign bus_data   = beat_data[owner];
    assign bus_dest   = beat_dest[owner];
    assign bus_return = beat_return[owner];
    assign bus_rw     = beat_rw[owner];
    assign bus_size   = beat_size[owner];

endmodule

// ==== logic/bus_deserializer.sv ====
`timescale 1ns/1ps

module bus_deserializer #(
    parameter bus_pkg::node_t node_id = '0
) (
    input  logic            clk_bus,
    input  logic            reset,

    // shared bus
    input  logic            bus_valid,
    input  bus_pkg::addr_t  bus_addr,
    input  bus_pkg::word_t  bus_data,
    input  bus_pkg::node_t  bus_dest,
    input  bus_pkg::node_t  bus_return,
    input  logic            bus_rw,
    input  bus_pkg::size_t  bus_size,

    // assembled block
    output logic            out_valid,
    output bus_pkg::addr_t  out_addr,
    output bus_pkg::block_t out_data,
    output bus_pkg::node_t  out_return,
    output logic            out_rw,
    output bus_pkg::size_t  out_size
);

    bus_pkg::beat_cnt_t rx_count;
    bus_pkg::block_t    asm_block;
    logic               hit;
    logic               last_beat;

    assign hit       = bus_valid && (bus_dest == node_id);
    assign last_beat = hit &&
                       (bus_pkg::beat_cnt_t'(rx_count + 1'b1) ==
                        bus_pkg::beats_for_size(bus_size));

    //////////////////////////////////////////////////////////////////////
    // beat counting
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_bus) begin
        if (reset) begin
            rx_count  <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= last_beat;
            if (last_beat) begin
                rx_count <= '0;
            end else if (hit) begin
                rx_count <= rx_count + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // assembly
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_bus) begin
        if (hit) begin
            if (rx_count == '0) begin
                // first beat clears the upper words, header taken from it
                asm_block  <= bus_pkg::block_t'(bus_data);
                out_addr   <= bus_addr;
                out_return <= bus_return;
                out_rw     <= bus_rw;
                out_size   <= bus_size;
            end else begin
                asm_block[int'(rx_count)*bus_pkg::word_bits +: bus_pkg::word_bits] <= bus_data;
            end
        end
    end

    // stays put until the next block starts
    assign out_data = asm_block;

endmodule

// ==== logic/bus_fabric_top.sv ====
`timescale 1ns/1ps

module bus_fabric_top (
    input  logic            clk_bus,
    input  logic            reset,

    // per source
    input  logic            blk_valid  [bus_pkg::num_sources],
    input  bus_pkg::addr_t  blk_addr   [bus_pkg::num_sources],
    input  bus_pkg::block_t blk_data   [bus_pkg::num_sources],
    input  bus_pkg::node_t  blk_dest   [bus_pkg::num_sources],
    input  bus_pkg::node_t  blk_return [bus_pkg::num_sources],
    input  logic            blk_rw     [bus_pkg::num_sources],
    input  bus_pkg::size_t  blk_size   [bus_pkg::num_sources],
    output logic            free_block [bus_pkg::num_sources],
    output logic            full_block [bus_pkg::num_sources],

    // per sink
    output logic            out_valid  [bus_pkg::num_sinks],
    output bus_pkg::addr_t  out_addr   [bus_pkg::num_sinks],
    output bus_pkg::block_t out_data   [bus_pkg::num_sinks],
    output bus_pkg::node_t  out_return [bus_pkg::num_sinks],
    output logic            out_rw     [bus_pkg::num_sinks],
    output bus_pkg::size_t  out_size   [bus_pkg::num_sinks],

    output logic            bus_valid
);

    logic            req         [bus_pkg::num_sources];
    logic            rel         [bus_pkg::num_sources];
    logic            ack         [bus_pkg::num_sources];
    logic            grant       [bus_pkg::num_sources];

    logic            beat_valid  [bus_pkg::num_sources];
    bus_pkg::addr_t  beat_addr   [bus_pkg::num_sources];
    bus_pkg::word_t  beat_data   [bus_pkg::num_sources];
    bus_pkg::node_t  beat_dest   [bus_pkg::num_sources];
    bus_pkg::node_t  beat_return [bus_pkg::num_sources];
    logic            beat_rw     [bus_pkg::num_sources];
    bus_pkg::size_t  beat_size   [bus_pkg::num_sources];

    bus_pkg::addr_t  bus_addr;
    bus_pkg::word_t  bus_data;
    bus_pkg::node_t  bus_dest;
    bus_pkg::node_t  bus_return;
    logic            bus_rw;
    bus_pkg::size_t  bus_size;

    //////////////////////////////////////////////////////////////////////
    // sources
    //////////////////////////////////////////////////////////////////////
    for (genvar s = 0; s < bus_pkg::num_sources; s++) begin : g_ser
        bus_serializer u_bus_serializer (
            .clk_bus     (clk_bus),
            .reset       (reset),
            .blk_valid   (blk_valid[s]),
            .blk_addr    (blk_addr[s]),
            .blk_data    (blk_data[s]),
            .blk_dest    (blk_dest[s]),
            .blk_return  (blk_return[s]),
            .blk_rw      (blk_rw[s]),
            .blk_size    (blk_size[s]),
            .free_block  (free_block[s]),
            .full_block  (full_block[s]),
            .ack         (ack[s]),
            .grant       (grant[s]),
            .req         (req[s]),
            .rel         (rel[s]),
            .beat_valid  (beat_valid[s]),
            .beat_addr   (beat_addr[s]),
            .beat_data   (beat_data[s]),
            .beat_dest   (beat_dest[s]),
            .beat_return (beat_return[s]),
            .beat_rw     (beat_rw[s]),
            .beat_size   (beat_size[s])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // arbitration and bus mux
    //////////////////////////////////////////////////////////////////////
    bus_controller u_bus_controller (
        .clk_bus     (clk_bus),
        .reset       (reset),
        .req         (req),
        .rel         (rel),
        .ack         (ack),
        .grant       (grant),
        .beat_valid  (beat_valid),
        .beat_addr   (beat_addr),
        .beat_data   (beat_data),
        .beat_dest   (beat_dest),
        .beat_return (beat_return),
        .beat_rw     (beat_rw),
        .beat_size   (beat_size),
        .bus_valid   (bus_valid),
        .bus_addr    (bus_addr),
        .bus_data    (bus_data),
        .bus_dest    (bus_dest),
        .bus_return  (bus_return),
        .bus_rw      (bus_rw),
        .bus_size    (bus_size)
    );

    //////////////////////////////////////////////////////////////////////
    // sinks, node id equals sink index
    //////////////////////////////////////////////////////////////////////
    for (genvar d = 0; d < bus_pkg::num_sinks; d++) begin : g_deser
        bus_deserializer #(
            .node_id (bus_pkg::node_t'(d))
        ) u_bus_deserializer (
            .clk_bus    (clk_bus),
            .reset      (reset),
            .bus_valid  (bus_valid),
            .bus_addr   (bus_addr),
            .bus_data   (bus_data),
            .bus_dest   (bus_dest),
            .bus_return (bus_return),
            .bus_rw     (bus_rw),
            .bus_size   (bus_size),
            .out_valid  (out_valid[d]),
            .out_addr   (out_addr[d]),
            .out_data   (out_data[d]),
            .out_return (out_return[d]),
            .out_rw     (out_rw[d]),
            .out_size   (out_size[d])
        );
    end

endmodule

// ==== testbench/tb_bus_fabric.sv ====
`timescale 1ns/1ps

module tb_bus_fabric;

    localparam int    max_lines    = 64;
    localparam int    drain_cycles = 10;
    localparam string trace_path   = "testbench/fabric_trace.txt";

    logic            clk_bus;
    logic            reset;
    logic            blk_valid  [bus_pkg::num_sources];
    bus_pkg::addr_t  blk_addr   [bus_pkg::num_sources];
    bus_pkg::block_t blk_data   [bus_pkg::num_sources];
    bus_pkg::node_t  blk_dest   [bus_pkg::num_sources];
    bus_pkg::node_t  blk_return [bus_pkg::num_sources];
    logic            blk_rw     [bus_pkg::num_sources];
    bus_pkg::size_t  blk_size   [bus_pkg::num_sources];
    logic            free_block [bus_pkg::num_sources];
    logic            full_block [bus_pkg::num_sources];
    logic            out_valid  [bus_pkg::num_sinks];
    bus_pkg::addr_t  out_addr   [bus_pkg::num_sinks];
    bus_pkg::block_t out_data   [bus_pkg::num_sinks];
    bus_pkg::node_t  out_return [bus_pkg::num_sinks];
    logic            out_rw     [bus_pkg::num_sinks];
    bus_pkg::size_t  out_size   [bus_pkg::num_sinks];
    logic            bus_valid;

    // sends and expected deliveries from the trace
    int              send_count;
    int              send_gap    [max_lines];
    int              send_src    [max_lines];
    bus_pkg::addr_t  send_addr   [max_lines];
    bus_pkg::block_t send_data   [max_lines];
    bus_pkg::node_t  send_dest   [max_lines];
    bus_pkg::node_t  send_return [max_lines];
    logic            send_rw     [max_lines];
    bus_pkg::size_t  send_size   [max_lines];
    int              exp_count;
    int              exp_sink    [max_lines];
    bus_pkg::addr_t  exp_addr    [max_lines];
    bus_pkg::block_t exp_data    [max_lines];
    bus_pkg::node_t  exp_return  [max_lines];
    logic            exp_rw      [max_lines];
    bus_pkg::size_t  exp_size    [max_lines];
    int              next_exp    [bus_pkg::num_sinks];

    int              cycle_count = 0;
    int              cycle_limit = 200;
    logic            first_sent  = 1'b0;

    bus_fabric_top u_bus_fabric_top (
        .clk_bus    (clk_bus),
        .reset      (reset),
        .blk_valid  (blk_valid),
        .blk_addr   (blk_addr),
        .blk_data   (blk_data),
        .blk_dest   (blk_dest),
        .blk_return (blk_return),
        .blk_rw     (blk_rw),
        .blk_size   (blk_size),
        .free_block (free_block),
        .full_block (full_block),
        .out_valid  (out_valid),
        .out_addr   (out_addr),
        .out_data   (out_data),
        .out_return (out_return),
        .out_rw     (out_rw),
        .out_size   (out_size),
        .bus_valid  (bus_valid)
    );

    initial begin
        clk_bus = 1'b0;
        forever #4 clk_bus = ~clk_bus;
    end

    //////////////////////////////////////////////////////////////////////
    // error handling and compare tasks
    //////////////////////////////////////////////////////////////////////
    task automatic stop_with_error(input string what);
        $display("%s", what);
        $display("** FAIL **");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_block(input string name, input bus_pkg::block_t got,
                               input bus_pkg::block_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input bus_pkg::addr_t got,
                              input bus_pkg::addr_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_node(input string name, input bus_pkg::node_t got,
                              input bus_pkg::node_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_size(input string name, input bus_pkg::size_t got,
                              input bus_pkg::size_t exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // trace parsing
    //////////////////////////////////////////////////////////////////////
    task automatic read_trace();
        int              fd;
        int              n;
        string           line;
        string           kind;
        int              gap;
        int              src;
        int              sink;
        bus_pkg::addr_t  addr;
        bus_pkg::block_t data;
        bus_pkg::node_t  dest;
        bus_pkg::node_t  ret;
        logic            rw;
        bus_pkg::size_t  size;
        send_count = 0;
        exp_count  = 0;
        fd = $fopen(trace_path, "r");
        if (fd == 0) begin
            stop_with_error("cannot open the trace file");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            kind = "";
            if (n > 0 && line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%s", kind);
            end
            if (kind == "send") begin
                n = $sscanf(line, "%s %d %d %h %h %h %h %h %h", kind, gap, src,
                            addr, data, dest, ret, rw, size);
                if (n != 9 || src < 0 || src >= bus_pkg::num_sources ||
                    send_count >= max_lines) begin
                    stop_with_error("badly formed send line in the trace");
                end
                send_gap[send_count]    = gap;
                send_src[send_count]    = src;
                send_addr[send_count]   = addr;
                send_data[send_count]   = data;
                send_dest[send_count]   = dest;
                send_return[send_count] = ret;
                send_rw[send_count]     = rw;
                send_size[send_count]   = size;
                send_count++;
            end else if (kind == "expect") begin
                n = $sscanf(line, "%s %d %h %h %h %h %h", kind, sink, addr, data, ret, rw, size);
                if (n != 7 || sink < 0 || sink >= bus_pkg::num_sinks ||
                    exp_count >= max_lines) begin
                    stop_with_error("badly formed expect line in the trace");
                end
                exp_sink[exp_count]   = sink;
                exp_addr[exp_count]   = addr;
                exp_data[exp_count]   = data;
                exp_return[exp_count] = ret;
                exp_rw[exp_count]     = rw;
                exp_size[exp_count]   = size;
                exp_count++;
            end else if (kind != "") begin
                stop_with_error({"unknown line kind in the trace: ", kind});
            end
        end
        $fclose(fd);
        if (send_count == 0) begin
            stop_with_error("the trace holds no send lines");
        end
    endtask

    // next expectation for a sink, -1 when none is left
    function automatic int find_expect(input int s);
        for (int i = next_exp[s]; i < exp_count; i++) begin
            if (exp_sink[i] == s) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic int leftover_count();
        int total;
        total = 0;
        for (int s = 0; s < bus_pkg::num_sinks; s++) begin
            for (int i = next_exp[s]; i < exp_count; i++) begin
                if (exp_sink[i] == s) begin
                    total++;
                end
            end
        end
        return total;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // driving and monitoring
    //////////////////////////////////////////////////////////////////////
    task automatic clear_inputs();
        for (int s = 0; s < bus_pkg::num_sources; s++) begin
            blk_valid[s]  = 1'b0;
            blk_addr[s]   = '0;
            blk_data[s]   = '0;
            blk_dest[s]   = '0;
            blk_return[s] = '0;
            blk_rw[s]     = 1'b0;
            blk_size[s]   = '0;
        end
    endtask

    task automatic apply_send(input int i);
        int src;
        src = send_src[i];
        blk_valid[src]  = 1'b1;
        blk_addr[src]   = send_addr[i];
        blk_data[src]   = send_data[i];
        blk_dest[src]   = send_dest[i];
        blk_return[src] = send_return[i];
        blk_rw[src]     = send_rw[i];
        blk_size[src]   = send_size[i];
        first_sent     <= 1'b1;
    endtask

    task automatic check_delivery(input int s);
        int idx;
        idx = find_expect(s);
        if (!first_sent) begin
            stop_with_error($sformatf("sink %0d delivered a block before any send", s));
        end else if (idx < 0) begin
            stop_with_error($sformatf("sink %0d delivered a block with no expect line", s));
        end else begin
            check_addr($sformatf("out_addr[%0d]", s), out_addr[s], exp_addr[idx]);
            check_block($sformatf("out_data[%0d]", s), out_data[s], exp_data[idx]);
            check_node($sformatf("out_return[%0d]", s), out_return[s], exp_return[idx]);
            check_flag($sformatf("out_rw[%0d]", s), out_rw[s], exp_rw[idx]);
            check_size($sformatf("out_size[%0d]", s), out_size[s], exp_size[idx]);
            next_exp[s] = idx + 1;
        end
    endtask

    // out_valid is registered, so one falling edge sees each pulse
    always @(negedge clk_bus) begin
        for (int s = 0; s < bus_pkg::num_sinks; s++) begin
            if (out_valid[s] === 1'b1) begin
                check_delivery(s);
            end
        end
    end

    always @(posedge clk_bus) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            stop_with_error($sformatf("run did not finish within %0d cycles", cycle_limit));
        end
    end

    initial begin
        reset = 1'b1;
        clear_inputs();
        for (int s = 0; s < bus_pkg::num_sinks; s++) begin
            next_exp[s] = 0;
        end
        read_trace();
        cycle_limit = send_count * 40 + 200;

        repeat (16) @(posedge clk_bus);
        @(negedge clk_bus);
        reset = 1'b0;

        // idle state straight out of reset
        for (int s = 0; s < bus_pkg::num_sources; s++) begin
            check_flag($sformatf("free_block[%0d]", s), free_block[s], 1'b1);
            check_flag($sformatf("full_block[%0d]", s), full_block[s], 1'b0);
        end
        check_flag("bus_valid", bus_valid, 1'b0);

        for (int i = 0; i < send_count; i++) begin
            repeat (send_gap[i]) @(negedge clk_bus);
            while (free_block[send_src[i]] !== 1'b1) begin
                @(negedge clk_bus);
            end
            apply_send(i);
            // a zero gap on the other source shares this cycle
            if (!((i + 1 < send_count) && (send_gap[i + 1] == 0) &&
                  (send_src[i + 1] != send_src[i]))) begin
                @(negedge clk_bus);
                clear_inputs();
            end
        end

        while (!(free_block[0] === 1'b1 && free_block[1] === 1'b1)) begin
            @(negedge clk_bus);
        end
        repeat (drain_cycles) @(negedge clk_bus);

        if (leftover_count() != 0) begin
            stop_with_error($sformatf("%0d expected blocks never arrived", leftover_count()));
        end else begin
            $display("** PASS **");
            $finish;
        end
    end

endmodule

// ==== testbench/fabric_trace.txt ====
# send   gap(dec) src(dec) addr data dest return rw size   (hex after src)
# expect sink(dec) addr data return rw size                (hex after sink)

send 4 0 1a2b 00112233445566778899aabbccddeeff 1 0 1 0010
expect 1 1a2b 00112233445566778899aabbccddeeff 0 1 0010

send 30 1 0404 0123456789abcdeffedcba9876543210 0 3 0 0005
expect 0 0404 0000000000000000fedcba9876543210 3 0 0005

send 30 0 7ff0 a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0 1 2 1 0010
send 0 1 0123 11111111222222223333333344444444 0 1 1 0008
expect 1 7ff0 a5a5a5a55a5a5a5a0f0f0f0ff0f0f0f0 2 1 0010
expect 0 0123 00000000000000003333333344444444 1 1 0008

send 30 0 1000 deadbeefcafebabe0badf00d12345678 0 5 0 000c
send 0 0 1004 99999999888888887777777766666666 0 6 1 0004
send 0 0 1008 0f1e2d3c4b5a69788796a5b4c3d2e1f0 0 4 0 0007
expect 0 1000 00000000cafebabe0badf00d12345678 5 0 000c
expect 0 1004 00000000000000000000000066666666 6 1 0004
expect 0 1008 00000000000000008796a5b4c3d2e1f0 4 0 0007

send 30 1 2000 aaaaaaaabbbbbbbbccccccccdddddddd 7 0 1 0008
send 0 1 2004 13579bdf2468ace0fedcba9801234567 1 2 0 0003
expect 1 2004 00000000000000000000000001234567 2 0 0003

// ==== build.f ====
logic/bus_pkg.sv
logic/bus_serializer.sv
logic/bus_controller.sv
logic/bus_deserializer.sv
logic/bus_fabric_top.sv
testbench/tb_bus_fabric.sv

// ==== Bender.yml ====
package:
  name: bus_fabric

sources:
  - logic/bus_pkg.sv
  - logic/bus_serializer.sv
  - logic/bus_controller.sv
  - logic/bus_deserializer.sv
  - logic/bus_fabric_top.sv
  - target: test
    files:
      - testbench/tb_bus_fabric.sv
